/* rtl/bank_scrubber.sv */
// Background scrubber for one ECC bank
// Each trigger scrubs one word, read first, then judged and fixed if needed
// Reads only when the core leaves the array idle
`timescale 1ns/1ns
`default_nettype none

`include "tcdm_params.svh"

module bank_scrubber (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            trigger_i,
  input  logic            core_req_i,  // Array claimed by the core
  input  logic            single_i,
  input  logic            double_i,
  output logic            scrub_rd_o,
  output logic            scrub_wr_o,
  output tcdm_pkg::widx_t scrub_idx_o,
  output logic            fix_o,
  output logic            uncorrectable_o
);

  import tcdm_pkg::*;

  localparam widx_t LastIdx = widx_t'(`TCDM_BANK_WORDS - 1);

  logic  pending_q;  // Trigger seen, word not yet read
  logic  check_q;    // Decoder shows the scrubbed word
  widx_t idx_q;

  // Wait for a cycle without core traffic
  assign scrub_rd_o = pending_q && !core_req_i && !check_q;

  // Verdict on the word read last cycle
  assign fix_o           = check_q && single_i;
  assign uncorrectable_o = check_q && double_i;
  assign scrub_wr_o      = fix_o;  // Writeback only for a correctable word
  assign scrub_idx_o     = idx_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
      check_q   <= 1'b0;
      idx_q     <= '0;
    end else begin
      // New trigger wins over the clear
      pending_q <= trigger_i || (pending_q && !scrub_rd_o);
      check_q   <= scrub_rd_o;
      if (check_q) begin
        // Step on after the verdict
        idx_q <= (idx_q == LastIdx) ? '0 : idx_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/ecc_bank.sv */
// One SEC-DED protected TCDM bank
// Full writes and reads are granted at once, partial writes take a
// read-modify-write pass, scrub writeback steals one cycle
`timescale 1ns/1ns
`default_nettype none

`include "tcdm_params.svh"

module ecc_bank (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    test_mode_i,
  input  logic                    scrub_trigger_i,
  input  logic                    req_i,
  input  logic                    wen_i,  // Low for write
  input  tcdm_pkg::be_t           be_i,
  input  logic [`TCDM_ADDR_W-1:0] addr_i,
  input  tcdm_pkg::data_t         wdata_i,
  input  tcdm_pkg::id_t           id_i,
  input  tcdm_pkg::code_t         flip_mask_i,
  output logic                    gnt_o,
  output tcdm_pkg::data_t         rdata_o,
  output tcdm_pkg::id_t           rid_o,
  output logic                    single_error_o,
  output logic                    multi_error_o,
  output logic                    scrub_fix_o,
  output logic                    scrub_uncorrectable_o
);

  import tcdm_pkg::*;

  bank_state_e state_q, state_d;

  code_t mem_q [`TCDM_BANK_WORDS];
  code_t rd_code_q;  // Codeword read last cycle
  code_t enc_code;
  code_t mem_wcode;
  data_t enc_data;
  data_t dec_data;
  data_t merged;
  data_t rdata_q;    // Keeps read data between reads
  id_t   rid_q;
  widx_t req_idx;
  widx_t scrub_idx;
  widx_t mem_idx;
  logic  core_rd, core_full_wr, core_rmw_rd, core_wr;
  logic  mem_re, mem_we;
  logic  dec_single, dec_double;
  logic  scrub_rd, scrub_wr;
  logic  rd_valid_q; // Decoder shows a core read

  assign req_idx = addr_i[$bits(widx_t)+1:2];  // Word address

  // Core request decode, only taken in IDLE
  assign core_rd      = (state_q == IDLE) && req_i && wen_i;
  assign core_full_wr = (state_q == IDLE) && req_i && !wen_i && (&be_i);
  assign core_rmw_rd  = (state_q == IDLE) && req_i && !wen_i && !(&be_i);
  assign core_wr      = core_full_wr || (state_q == RMW_WRITE);

  // Partial write waits one cycle, scrub writeback blocks one cycle
  assign gnt_o = (state_q == RMW_WRITE) || ((state_q == IDLE) && !core_rmw_rd);

  // Byte merge of new data over the corrected old word
  always_comb begin
    for (int b = 0; b < 4; b++) begin
      merged[8*b +: 8] = be_i[b] ? wdata_i[8*b +: 8] : dec_data[8*b +: 8];
    end
  end

  always_comb begin
    unique case (state_q)
      RMW_WRITE:   enc_data = merged;
      SCRUB_WRITE: enc_data = dec_data;  // Corrected scrub word
      default:     enc_data = wdata_i;
    endcase
  end

  // Test corruption hits core writes only
  assign mem_wcode = (core_wr && test_mode_i) ? (enc_code ^ flip_mask_i) : enc_code;

  assign mem_we  = core_wr || scrub_wr;
  assign mem_re  = core_rd || core_rmw_rd || scrub_rd;
  assign mem_idx = (scrub_rd || (state_q == SCRUB_WRITE)) ? scrub_idx : req_idx;

  // Single port array, read data registered
  always_ff @(posedge clk_i) begin
    if (mem_we) begin
      mem_q[mem_idx] <= mem_wcode;
    end
    if (mem_re) begin
      rd_code_q <= mem_q[mem_idx];
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (core_rmw_rd) begin
          state_d = RMW_WRITE;
        end else if (scrub_rd) begin
          state_d = SCRUB_WRITE;
        end
      end
      RMW_WRITE:   state_d = IDLE;
      SCRUB_WRITE: state_d = IDLE;
      default:     state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      rd_valid_q <= 1'b0;
      rid_q      <= '0;
      rdata_q    <= '0;
    end else begin
      state_q    <= state_d;
      rd_valid_q <= core_rd;
      if (core_rd) begin
        rid_q <= id_i;
      end
      if (rd_valid_q) begin
        rdata_q <= dec_data;
      end
    end
  end

  assign rdata_o        = rd_valid_q ? dec_data : rdata_q;
  assign rid_o          = rid_q;
  assign single_error_o = rd_valid_q && dec_single;  // Core reads only
  assign multi_error_o  = rd_valid_q && dec_double;

  // Write path encoder
  secded_codec u_enc (
    .enc_data_i     (enc_data),
    .enc_code_o     (enc_code),
    .dec_code_i     ('0),
    .dec_data_o     (),
    .dec_syndrome_o (),
    .dec_single_o   (),
    .dec_double_o   ()
  );

  // Read path decoder, shared by core reads, RMW and scrub
  secded_codec u_dec (
    .enc_data_i     ('0),
    .enc_code_o     (),
    .dec_code_i     (rd_code_q),
    .dec_data_o     (dec_data),
    .dec_syndrome_o (),
    .dec_single_o   (dec_single),
    .dec_double_o   (dec_double)
  );

  bank_scrubber u_scrubber (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .trigger_i       (scrub_trigger_i),
    .core_req_i      (req_i || (state_q != IDLE)),  // Array busy
    .single_i        (dec_single),
    .double_i        (dec_double),
    .scrub_rd_o      (scrub_rd),
    .scrub_wr_o      (scrub_wr),
    .scrub_idx_o     (scrub_idx),
    .fix_o           (scrub_fix_o),
    .uncorrectable_o (scrub_uncorrectable_o)
  );

endmodule

`default_nettype wire

/* rtl/secded_codec.sv */
// SEC-DED Hamming codec, 32 data bits in a 39-bit codeword
// Encoder and decoder are independent halves
// A bank uses one instance per path and leaves the other half idle
`timescale 1ns/1ns
`default_nettype none

module secded_codec (
  input  tcdm_pkg::data_t     enc_data_i,
  output tcdm_pkg::code_t     enc_code_o,
  input  tcdm_pkg::code_t     dec_code_i,
  output tcdm_pkg::data_t     dec_data_o,
  output tcdm_pkg::syndrome_t dec_syndrome_o,
  output logic                dec_single_o,
  output logic                dec_double_o
);

  import tcdm_pkg::*;

  // Hamming position of every data bit, powers of two are check bits
  function automatic logic [31:0][5:0] gen_data_pos();
    logic [31:0][5:0] pos;
    int unsigned      j;
    pos = '0;
    j   = 0;
    for (int unsigned p = 1; p < 39; p++) begin
      if ((p & (p - 1)) != 0) begin
        pos[j] = 6'(p);
        j++;
      end
    end
    return pos;
  endfunction

  localparam logic [31:0][5:0] DataPos = gen_data_pos();

  // Check bit k covers every position with bit k set
  function automatic logic [5:0] calc_chk(data_t d);
    logic [5:0] c;
    c = '0;
    for (int j = 0; j < 32; j++) begin
      for (int k = 0; k < 6; k++) begin
        if (DataPos[j][k]) begin
          c[k] = c[k] ^ d[j];
        end
      end
    end
    return c;
  endfunction

  logic [5:0] enc_chk;
  logic [5:0] dec_chk;  // Check bits recomputed from stored data
  logic [5:0] syn;      // Position of a single flipped bit
  logic       par_err;

  // Encoder
  assign enc_chk          = calc_chk(enc_data_i);
  assign enc_code_o[37:0] = {enc_chk, enc_data_i};
  assign enc_code_o[38]   = ^{enc_chk, enc_data_i};  // Even parity overall

  // Decoder
  assign dec_chk        = calc_chk(dec_code_i[31:0]);
  assign syn            = dec_chk ^ dec_code_i[37:32];
  assign par_err        = ^dec_code_i;  // Zero on a clean word
  assign dec_syndrome_o = {par_err, syn};

  // Odd flip count is treated as one flip
  assign dec_single_o = par_err;
  // Even count but nonzero syndrome
  assign dec_double_o = !par_err && (syn != '0);

  // Flip the data bit the syndrome points at
  always_comb begin
    dec_data_o = dec_code_i[31:0];  // Raw bits on clean or double
    for (int j = 0; j < 32; j++) begin
      if (par_err && (DataPos[j] == syn)) begin
        dec_data_o[j] = ~dec_code_i[j];
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/tcdm_banks.sv */
// Cluster TCDM built from SEC-DED protected banks
// Bank ports come packed per bank, one request/grant port each
// Per bank error and scrub flags are merged into cluster pulses
`timescale 1ns/1ns
`default_nettype none

`include "tcdm_params.svh"

module tcdm_banks (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic                                         test_mode_i,
  input  logic                                         scrub_trigger_i,
  input  logic            [`TCDM_NB_BANKS-1:0]         req_i,
  input  logic            [`TCDM_NB_BANKS-1:0]         wen_i,
  input  tcdm_pkg::be_t   [`TCDM_NB_BANKS-1:0]         be_i,
  input  logic [`TCDM_NB_BANKS-1:0][`TCDM_ADDR_W-1:0]  addr_i,
  input  tcdm_pkg::data_t [`TCDM_NB_BANKS-1:0]         wdata_i,
  input  tcdm_pkg::id_t   [`TCDM_NB_BANKS-1:0]         id_i,
  input  tcdm_pkg::code_t [`TCDM_NB_BANKS-1:0]         flip_mask_i,
  output logic            [`TCDM_NB_BANKS-1:0]         gnt_o,
  output tcdm_pkg::data_t [`TCDM_NB_BANKS-1:0]         rdata_o,
  output tcdm_pkg::id_t   [`TCDM_NB_BANKS-1:0]         rid_o,
  output logic                                         scrub_fix_o,
  output logic                                         scrub_uncorrectable_o,
  output logic                                         ecc_single_error_o,
  output logic                                         ecc_multiple_error_o
);

  logic [`TCDM_NB_BANKS-1:0] single_err;
  logic [`TCDM_NB_BANKS-1:0] multi_err;
  logic [`TCDM_NB_BANKS-1:0] scrub_fix;
  logic [`TCDM_NB_BANKS-1:0] scrub_unc;

  // Any bank raises the cluster flag
  assign ecc_single_error_o    = |single_err;
  assign ecc_multiple_error_o  = |multi_err;
  assign scrub_fix_o           = |scrub_fix;
  assign scrub_uncorrectable_o = |scrub_unc;

  for (genvar i = 0; i < `TCDM_NB_BANKS; i++) begin : gen_banks
    ecc_bank u_bank (
      .clk_i                 (clk_i),
      .rst_ni                (rst_ni),
      .test_mode_i           (test_mode_i),
      .scrub_trigger_i       (scrub_trigger_i),  // All banks scrub together
      .req_i                 (req_i[i]),
      .wen_i                 (wen_i[i]),
      .be_i                  (be_i[i]),
      .addr_i                (addr_i[i]),
      .wdata_i               (wdata_i[i]),
      .id_i                  (id_i[i]),
      .flip_mask_i           (flip_mask_i[i]),
      .gnt_o                 (gnt_o[i]),
      .rdata_o               (rdata_o[i]),
      .rid_o                 (rid_o[i]),
      .single_error_o        (single_err[i]),
      .multi_error_o         (multi_err[i]),
      .scrub_fix_o           (scrub_fix[i]),
      .scrub_uncorrectable_o (scrub_unc[i])
    );
  end

endmodule

`default_nettype wire

/* rtl/tcdm_params.svh */
// Size macros for the ECC protected TCDM
// Included by the type package and by modules that size arrays or ports
`ifndef TCDM_PARAMS_SVH
`define TCDM_PARAMS_SVH

// Word interleaved banks in the cluster
`define TCDM_NB_BANKS 4

// 32-bit words per bank
`define TCDM_BANK_WORDS 256

// Request id carried back with read data
`define TCDM_ID_W 4

// Byte address seen at each bank port
`define TCDM_ADDR_W 32

`endif

/* rtl/tcdm_pkg.sv */
// Shared types for the ECC protected TCDM banks
// Word, codeword and index widths plus the bank FSM states
`default_nettype none

`include "tcdm_params.svh"

package tcdm_pkg;

  typedef logic [31:0] data_t;     // Unprotected word
  typedef logic [38:0] code_t;     // Data 31:0, check bits 37:32, parity 38
  typedef logic [6:0]  syndrome_t; // Bit 6 flags overall parity mismatch
  typedef logic [3:0]  be_t;       // One enable per byte

  typedef logic [`TCDM_ID_W-1:0] id_t;

  // Word index inside one bank
  typedef logic [$clog2(`TCDM_BANK_WORDS)-1:0] widx_t;

  typedef enum logic [1:0] {
    IDLE,        // Plain accesses and scrub reads
    RMW_WRITE,   // Merge and write of a partial write
    SCRUB_WRITE  // Scrub verdict and writeback
  } bank_state_e;

endpackage

`default_nettype wire

/* tb/tb_clk_gen.sv */
// Clock and reset source for the TCDM testbench
// 4 ns clock, reset held low for the first 4 rising edges
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;  // Asserted from time zero
    repeat (4) @(posedge clk_o);
    rst_no <= 1'b1;
  end

  always #2 clk_o = ~clk_o;

endmodule

`default_nettype wire

/* tb/tb_tcdm_banks.sv */
// Self-checking testbench for the ECC protected TCDM banks
// Random accesses against a reference memory, then injected bit flips
// on the read path and the scrub path
`timescale 1ns/1ns
`default_nettype none

`include "tcdm_params.svh"

module tb_tcdm_banks;

  import tcdm_pkg::*;

  localparam int NB      = `TCDM_NB_BANKS;
  localparam int NW      = 16;  // Low words of each bank used by the test
  localparam int TIMEOUT = 50;  // Cycles allowed per wait

  logic clk_i;
  logic rst_ni;
  logic test_mode, scrub_trigger;
  logic [NB-1:0] req, wen, gnt;
  be_t [NB-1:0] be;
  logic [NB-1:0][`TCDM_ADDR_W-1:0] addr;
  data_t [NB-1:0] wdata, rdata;
  id_t [NB-1:0] id, rid;
  code_t [NB-1:0] flip_mask;
  logic scrub_fix, scrub_unc, ecc_single, ecc_multi;

  data_t ref_mem [NB][NW];   // Intended data per word
  code_t ref_mask [NB][NW];  // Flips stored with each word
  int unsigned n_checks, n_errors;
  logic timed_out;           // Skips the remaining traffic

  tb_clk_gen u_clk_gen (.clk_o(clk_i), .rst_no(rst_ni));

  tcdm_banks u_dut (
    .clk_i (clk_i), .rst_ni (rst_ni), .test_mode_i (test_mode),
    .scrub_trigger_i (scrub_trigger), .req_i (req), .wen_i (wen), .be_i (be),
    .addr_i (addr), .wdata_i (wdata), .id_i (id), .flip_mask_i (flip_mask),
    .gnt_o (gnt), .rdata_o (rdata), .rid_o (rid), .scrub_fix_o (scrub_fix),
    .scrub_uncorrectable_o (scrub_unc), .ecc_single_error_o (ecc_single),
    .ecc_multiple_error_o (ecc_multi)
  );

  // Data bits fill the Hamming positions that are not powers of two
  function code_t ref_encode(data_t d);
    logic [38:1] hpos;
    code_t       c;
    int          j;
    hpos = '0;
    j    = 0;
    for (int p = 1; p <= 38; p++) begin
      if ((p & (p - 1)) != 0) begin
        hpos[p] = d[j];
        j++;
      end
    end
    c       = '0;
    c[31:0] = d;
    for (int k = 0; k < 6; k++) begin
      for (int p = 1; p <= 38; p++) begin
        if (p[k]) c[32+k] = c[32+k] ^ hpos[p];  // Position has bit k set
      end
    end
    c[38] = ^c[37:0];  // Overall parity
    return c;
  endfunction

  // Expected {single, multiple, data} for word d stored with flips m
  function logic [33:0] ref_read(data_t d, code_t m);
    code_t      c;
    code_t      r;
    logic [5:0] syn;
    logic       par;
    c   = ref_encode(d) ^ m;
    r   = ref_encode(c[31:0]);
    syn = r[37:32] ^ c[37:32];
    par = ^c;
    return {par, !par && (syn != '0), par ? d : c[31:0]};
  endfunction

  task check_val(input string name, input logic [63:0] got, input logic [63:0] want);
    n_checks++;
    if (got !== want) begin
      n_errors++;
      $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, want);
    end
  endtask

  // Request stays up until gnt is seen mid cycle, then drops at the grant edge
  task wait_grant(input int b);
    int cnt;
    cnt = 0;
    @(negedge clk_i);
    while (!gnt[b] && cnt < TIMEOUT) begin
      cnt++;
      @(negedge clk_i);
    end
    if (!gnt[b]) begin
      $display("Timeout: bank %0d never granted the request", b);
      n_errors++;
      timed_out = 1'b1;
    end
    @(posedge clk_i);
    req[b]       <= 1'b0;
    test_mode    <= 1'b0;
    flip_mask[b] <= '0;
  endtask

  task write_word(input int b, input int idx, input data_t d, input be_t wbe, input code_t m);
    if (timed_out) return;
    @(posedge clk_i);
    req[b]       <= 1'b1;
    wen[b]       <= 1'b0;
    be[b]        <= wbe;
    addr[b]      <= idx << 2;
    wdata[b]     <= d;
    test_mode    <= (m != '0);
    flip_mask[b] <= m;
    wait_grant(b);
    for (int i = 0; i < 4; i++) begin
      if (wbe[i]) ref_mem[b][idx][8*i +: 8] = d[8*i +: 8];
    end
    ref_mask[b][idx] = m;
  endtask

  task read_word(input int b, input int idx);
    logic [33:0] pred;
    id_t         rid_exp;
    if (timed_out) return;
    pred    = ref_read(ref_mem[b][idx], ref_mask[b][idx]);
    rid_exp = id_t'($urandom);
    @(posedge clk_i);
    req[b]  <= 1'b1;
    wen[b]  <= 1'b1;
    addr[b] <= idx << 2;
    id[b]   <= rid_exp;
    wait_grant(b);
    if (timed_out) return;
    @(negedge clk_i);  // Response cycle
    check_val($sformatf("rdata_o[%0d]", b), rdata[b], pred[31:0]);
    check_val($sformatf("rid_o[%0d]", b), rid[b], rid_exp);
    check_val("ecc_single_error_o", ecc_single, pred[33]);
    check_val("ecc_multiple_error_o", ecc_multi, pred[32]);
  endtask

  initial begin
    int unsigned seed;
    int          b, idx, bit_a;
    logic        seen_fix, seen_unc;
    seed = 92;
    void'($urandom(seed));
    n_checks  = 0;
    n_errors  = 0;
    timed_out = 1'b0;
    test_mode = 1'b0;
    scrub_trigger = 1'b0;
    req = '0;
    wen = '1;
    be = '0;
    addr = '0;
    wdata = '0;
    id = '0;
    flip_mask = '0;
    for (int i = 0; i < 20 && rst_ni !== 1'b1; i++) @(posedge clk_i);
    if (rst_ni !== 1'b1) begin
      $display("Timeout: reset was never released");
      n_errors++;
      timed_out = 1'b1;
    end
    @(negedge clk_i);
    check_val("gnt_o", gnt, {NB{1'b1}});
    for (int i = 0; i < NB; i++) begin
      check_val($sformatf("rdata_o[%0d]", i), rdata[i], '0);
      check_val($sformatf("rid_o[%0d]", i), rid[i], '0);
    end
    check_val("scrub_fix_o", scrub_fix, 1'b0);
    check_val("scrub_uncorrectable_o", scrub_unc, 1'b0);
    check_val("ecc_single_error_o", ecc_single, 1'b0);
    check_val("ecc_multiple_error_o", ecc_multi, 1'b0);

    // Clean fill, then random full writes and reads
    for (b = 0; b < NB; b++) begin
      for (idx = 0; idx < NW; idx++) write_word(b, idx, $urandom, 4'hf, '0);
    end
    for (int n = 0; n < 200; n++) begin
      b   = $urandom_range(NB - 1, 0);
      idx = $urandom_range(NW - 1, 0);
      if ($urandom_range(1, 0)) read_word(b, idx);
      else write_word(b, idx, $urandom, 4'hf, '0);
    end
    // Partial writes go through read-modify-write
    for (int n = 0; n < 40; n++) begin
      b   = $urandom_range(NB - 1, 0);
      idx = $urandom_range(NW - 1, 0);
      write_word(b, idx, $urandom, be_t'($urandom_range(14, 0)), '0);
      read_word(b, idx);
    end
    write_word(2, 3, $urandom, 4'hf, code_t'(1) << $urandom_range(38, 0));  // Single flip
    read_word(2, 3);
    bit_a = $urandom_range(38, 0);
    write_word(3, 5, $urandom, 4'hf,
               (code_t'(1) << bit_a) | (code_t'(1) << ((bit_a + $urandom_range(38, 1)) % 39)));
    read_word(3, 5);

    // Scrub pass over index 0 of every bank
    write_word(0, 0, $urandom, 4'hf, code_t'(1) << $urandom_range(38, 0));
    write_word(1, 0, $urandom, 4'hf, code_t'(3) << $urandom_range(37, 0));
    @(posedge clk_i);
    scrub_trigger <= 1'b1;
    @(posedge clk_i);
    scrub_trigger <= 1'b0;
    seen_fix = 1'b0;
    seen_unc = 1'b0;
    for (int i = 0; i < TIMEOUT && !(seen_fix && seen_unc) && !timed_out; i++) begin
      @(negedge clk_i);
      seen_fix = seen_fix | scrub_fix;
      seen_unc = seen_unc | scrub_unc;
      check_val("ecc_single_error_o", ecc_single, 1'b0);  // Scrub reads raise no core flags
      check_val("ecc_multiple_error_o", ecc_multi, 1'b0);
    end
    if (!timed_out && !(seen_fix && seen_unc)) begin
      $display("Timeout: scrub fix and uncorrectable flags did not both pulse");
      n_errors++;
    end
    ref_mask[0][0] = '0;  // Scrubber rewrote a clean codeword
    read_word(0, 0);
    read_word(1, 0);      // Still a double error

    $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+rtl
rtl/tcdm_pkg.sv
rtl/secded_codec.sv
rtl/bank_scrubber.sv
rtl/ecc_bank.sv
rtl/tcdm_banks.sv
tb/tb_clk_gen.sv
tb/tb_tcdm_banks.sv
